//--- common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// one transfer on the panel bus
	typedef struct packed {
		logic       rs;     // 0 instruction, 1 data register
		logic       rw;     // passed to the pin only
		logic [7:0] data;
	} lcd_cmd_t;

	// static setup choices for the init sequence
	typedef struct packed {
		logic two_line;    // function set N
		logic big_font;    // function set F
		logic display_on;  // display control D
		logic cursor_on;   // display control C
		logic blink_on;    // display control B
		logic increment;   // entry mode I/D
		logic shift;       // entry mode S
	} lcd_cfg_t;

	// timing in microseconds, scaled by CLK_PER_US in the modules
	localparam int T_POWER_UP  = 500;  // wait after reset
	localparam int T_SETUP     = 1;    // e low before pulse
	localparam int T_E_HIGH    = 13;   // e high time

	// total slot from start of transfer
	localparam int T_EXEC      = 50;   // ordinary command
	localparam int T_EXEC_LONG = 200;  // clear and return home

	// fixed instruction bytes
	localparam logic [7:0] CMD_CLEAR = 8'h01;

endpackage

`default_nettype wire

//--- source/lcd_cmd_queue.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_cmd_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmd_valid,
	input  lcd_pkg::lcd_cmd_t  cmd,
	output logic               credit,
	output logic               head_valid,
	output lcd_pkg::lcd_cmd_t  head,
	input  logic               pop
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(QUEUE_DEPTH);

	lcd_pkg::lcd_cmd_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// storage, written whenever the host spends a credit
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			mem[wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop;  // one credit back per released entry
			if (cmd_valid) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({cmd_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	assign head_valid = (count != '0);
	assign head       = mem[rd_ptr];  // only meaningful with head_valid

	// host wrote without holding a credit
	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst)
		cmd_valid |-> (count != CNT_FULL)
	) else $error("lcd_cmd_queue: write while full, host credit violation");

	// sequencer took a head that was not there
	a_no_underflow: assert property (
		@(posedge clk) disable iff (rst)
		pop |-> head_valid
	) else $error("lcd_cmd_queue: pop while empty");

endmodule

`default_nettype wire

//--- lcd_ctrl/lcd_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_init_seq #(
	parameter int CLK_PER_US = 30
) (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               head_valid,
	input  lcd_pkg::lcd_cmd_t  head,
	output logic               pop,
	output logic               issue,
	output lcd_pkg::lcd_cmd_t  issue_cmd,
	input  logic               done,
	output logic               init_done
);

	localparam int PWR_CYCLES = lcd_pkg::T_POWER_UP * CLK_PER_US;
	localparam int PWR_W      = (PWR_CYCLES > 1) ? $clog2(PWR_CYCLES) : 1;
	localparam logic [PWR_W-1:0] PWR_LAST = PWR_W'(PWR_CYCLES - 1);

	typedef enum logic [2:0] {
		ST_POWER,
		ST_SET0,  // function set
		ST_SET1,  // display control
		ST_SET2,  // clear
		ST_SET3,  // entry mode
		ST_RUN
	} state_t;

	state_t             state;
	logic [PWR_W-1:0]   pwr_cnt;
	logic               have_credit;  // engine slot is free
	logic               in_setup;
	lcd_pkg::lcd_cmd_t  setup_cmd;

	assign in_setup = (state inside {ST_SET0, ST_SET1, ST_SET2, ST_SET3});

	// setup commands are all instruction writes
	always_comb begin
		setup_cmd    = '0;
		setup_cmd.rs = 1'b0;
		setup_cmd.rw = 1'b0;
		case (state)
			ST_SET0: setup_cmd.data = {4'b0011, cfg.two_line, cfg.big_font, 2'b00};
			ST_SET1: setup_cmd.data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on};
			ST_SET2: setup_cmd.data = lcd_pkg::CMD_CLEAR;
			ST_SET3: setup_cmd.data = {6'b000001, cfg.increment, cfg.shift};
			default: setup_cmd.data = 8'h00;
		endcase
	end

	// host commands only once the fourth setup slot has finished
	assign pop       = (state == ST_RUN) && init_done && head_valid && have_credit;
	assign issue     = (in_setup && have_credit) || pop;
	assign issue_cmd = (state == ST_RUN) ? head : setup_cmd;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_POWER;
			pwr_cnt     <= '0;
			have_credit <= 1'b1;  // engine starts empty
			init_done   <= 1'b0;
		end else begin
			if (issue) begin
				have_credit <= 1'b0;
			end else if (done) begin
				have_credit <= 1'b1;
			end

			case (state)
				ST_POWER: begin
					if (pwr_cnt == PWR_LAST) begin
						state <= ST_SET0;
					end else begin
						pwr_cnt <= pwr_cnt + 1'b1;
					end
				end
				ST_SET0: if (issue) state <= ST_SET1;
				ST_SET1: if (issue) state <= ST_SET2;
				ST_SET2: if (issue) state <= ST_SET3;
				ST_SET3: if (issue) state <= ST_RUN;
				ST_RUN: begin
					// first done seen here belongs to entry mode
					if (done) begin
						init_done <= 1'b1;
					end
				end
				default: state <= ST_POWER;
			endcase
		end
	end

	// engine reported done for a slot that was never issued
	a_done_owed: assert property (
		@(posedge clk) disable iff (rst)
		done |-> !have_credit
	) else $error("lcd_init_seq: done while credit already held");

endmodule

`default_nettype wire

//--- lcd_ctrl/lcd_bus_cycle.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_cycle #(
	parameter int CLK_PER_US = 30
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  lcd_pkg::lcd_cmd_t  issue_cmd,
	output logic               done,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data
);

	localparam int SETUP_CYC  = lcd_pkg::T_SETUP * CLK_PER_US;
	localparam int E_HIGH_CYC = lcd_pkg::T_E_HIGH * CLK_PER_US;
	localparam int EXEC_CYC   = lcd_pkg::T_EXEC * CLK_PER_US;
	localparam int LONG_CYC   = lcd_pkg::T_EXEC_LONG * CLK_PER_US;
	localparam int CNT_W      = $clog2(LONG_CYC + 1);

	localparam logic [CNT_W-1:0] E_RISE_AT = CNT_W'(SETUP_CYC);
	localparam logic [CNT_W-1:0] E_FALL_AT = CNT_W'(SETUP_CYC + E_HIGH_CYC);
	localparam logic [CNT_W-1:0] EXEC_LAST = CNT_W'(EXEC_CYC);
	localparam logic [CNT_W-1:0] LONG_LAST = CNT_W'(LONG_CYC);

	logic             active;     // slot in progress
	logic             long_hold;  // clear or return home
	logic [CNT_W-1:0] slot_cnt;   // 1 in first driven cycle
	logic             slot_end;
	logic             is_long;

	// clear is 0x01, return home is 0x02 or 0x03
	assign is_long = !issue_cmd.rs &&
		((issue_cmd.data == lcd_pkg::CMD_CLEAR) || (issue_cmd.data[7:1] == 7'b0000001));

	assign slot_end = active && (slot_cnt == (long_hold ? LONG_LAST : EXEC_LAST));
	assign done     = slot_end;

	always_ff @(posedge clk) begin
		if (rst) begin
			active    <= 1'b0;
			long_hold <= 1'b0;
			slot_cnt  <= '0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= 8'h00;
		end else if (issue) begin
			active    <= 1'b1;
			long_hold <= is_long;
			slot_cnt  <= CNT_W'(1);
			rs        <= issue_cmd.rs;  // held for the whole slot
			rw        <= issue_cmd.rw;
			lcd_data  <= issue_cmd.data;
		end else if (active) begin
			if (slot_end) begin
				active   <= 1'b0;
				slot_cnt <= '0;
				rs       <= 1'b0;
				rw       <= 1'b0;
				lcd_data <= 8'h00;
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end

			// e high from cycle SETUP+1 through SETUP+E_HIGH
			if (slot_cnt == E_RISE_AT) begin
				e <= 1'b1;
			end else if (slot_cnt == E_FALL_AT) begin
				e <= 1'b0;
			end
		end
	end

	// sequencer must wait for done before the next issue
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst)
		issue |-> !active
	) else $error("lcd_bus_cycle: issue during active slot");

endmodule

`default_nettype wire

//--- source/lcd_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_subsys #(
	parameter int CLK_PER_US  = 30,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               cmd_valid,
	input  lcd_pkg::lcd_cmd_t  cmd,
	output logic               credit,
	output logic               init_done,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data
);

	logic               head_valid;
	lcd_pkg::lcd_cmd_t  head;
	logic               pop;
	logic               issue;
	lcd_pkg::lcd_cmd_t  issue_cmd;
	logic               done;

	// host side credit queue
	lcd_cmd_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.credit     (credit),
		.head_valid (head_valid),
		.head       (head),
		.pop        (pop)
	);

	lcd_init_seq #(
		.CLK_PER_US (CLK_PER_US)
	) u_init_seq (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.head_valid (head_valid),
		.head       (head),
		.pop        (pop),
		.issue      (issue),
		.issue_cmd  (issue_cmd),
		.done       (done),
		.init_done  (init_done)
	);

	// panel pins
	lcd_bus_cycle #(
		.CLK_PER_US (CLK_PER_US)
	) u_bus_cycle (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.issue_cmd  (issue_cmd),
		.done       (done),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

endmodule

`default_nettype wire

//--- tests/lcd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_tb;

	localparam int T           = 2;  // clock cycles per microsecond
	localparam int DEPTH       = 8;
	localparam int N_STREAM    = 40;
	localparam int N_BURST     = 16;
	localparam int N_EXPECTED  = 4 + N_STREAM + N_BURST;
	localparam int PWR_CYC     = 500 * T;
	localparam int E_HIGH_CYC  = 13 * T;
	localparam int EXEC_CYC    = 50 * T;
	localparam int LONG_CYC    = 200 * T;
	localparam int TIMEOUT_CYC = PWR_CYC + LONG_CYC * N_EXPECTED + 1000;

	logic               clk = 1'b0;
	logic               rst;
	lcd_pkg::lcd_cfg_t  cfg;
	logic               cmd_valid;
	lcd_pkg::lcd_cmd_t  cmd;
	logic               credit;
	logic               init_done;
	logic               e;
	logic               rs;
	logic               rw;
	logic [7:0]         lcd_data;

	logic [31:0]        rng;
	int                 cycle = 0;
	int                 release_cycle = 0;
	lcd_pkg::lcd_cmd_t  expected [N_EXPECTED];  // reference model in pin order
	int                 n_queued = 0;
	int                 sent = 0;
	int                 credit_pulses = 0;
	logic               stalled = 1'b0;

	// error counters by source
	int                 errors = 0;
	int                 early_errors = 0;
	int                 shape_errors = 0;
	int                 delivery_errors = 0;
	int                 credit_errors = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;

	// panel monitor state
	int                 rise_cnt = 0;
	int                 last_rise = 0;
	int                 high_start = 0;
	logic               last_long = 1'b0;
	logic               e_prev = 1'b0;
	lcd_pkg::lcd_cmd_t  cap;

	lcd_subsys #(
		.CLK_PER_US  (T),
		.QUEUE_DEPTH (DEPTH)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.credit    (credit),
		.init_done (init_done),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp, inout int err_count);
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg, inout int err_count);
		err_count = err_count + 1;
		$display("at %0t ns: %s", $time, msg);
	endtask

	task automatic finish_test(input string name, input int n_err);
		tests_run = tests_run + 1;
		if (n_err == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s: %0d errors", name, n_err);
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);  // xorshift32
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic lcd_pkg::lcd_cmd_t random_cmd();
		logic [31:0]       r;
		lcd_pkg::lcd_cmd_t c;
		r = next_rand();
		c.rs = r[8];
		c.rw = 1'b0;  // no reads from the panel
		c.data = r[7:0];
		return c;
	endfunction

	// HD44780 setup order with rs and rw low
	function automatic lcd_pkg::lcd_cmd_t setup_cmd_for(input int idx,
			input lcd_pkg::lcd_cfg_t c);
		lcd_pkg::lcd_cmd_t r;
		r = '0;
		case (idx)
			0: r.data = {4'b0011, c.two_line, c.big_font, 2'b00};
			1: r.data = {5'b00001, c.display_on, c.cursor_on, c.blink_on};
			2: r.data = 8'h01;
			default: r.data = {6'b000001, c.increment, c.shift};
		endcase
		return r;
	endfunction

	// clear display or return home
	function automatic logic is_long_cmd(input lcd_pkg::lcd_cmd_t c);
		return !c.rs && (c.data == 8'h01 || c.data == 8'h02 || c.data == 8'h03);
	endfunction

	function automatic int host_credits();
		return DEPTH - sent + credit_pulses;
	endfunction

	// called on a falling edge and returns on the next one
	task automatic send_cmd(input lcd_pkg::lcd_cmd_t c);
		while (host_credits() == 0) begin
			stalled = 1'b1;
			@(negedge clk);
		end
		expected[n_queued] = c;
		n_queued = n_queued + 1;
		sent = sent + 1;
		cmd = c;
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYC) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("*** FAILED ***");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!rst && credit === 1'b1) begin
			credit_pulses = credit_pulses + 1;
			if (credit_pulses > sent) begin
				report_failure("more credits returned than commands sent", credit_errors);
			end
		end
	end

	always @(posedge clk) begin
		lcd_pkg::lcd_cmd_t exp_cmd;
		int                min_gap;
		if (!rst) begin
			if (e && !e_prev) begin
				cap.rs = rs;
				cap.rw = rw;
				cap.data = lcd_data;
				if (rise_cnt == 0) begin
					if (cycle - release_cycle < PWR_CYC) begin
						report_failure("e pulsed before the power-up wait was over",
							early_errors);
					end
				end else begin
					min_gap = last_long ? LONG_CYC : EXEC_CYC;
					if (cycle - last_rise < min_gap) begin
						report_failure($sformatf("e rose %0d cycles after the previous rise, need %0d",
							cycle - last_rise, min_gap), shape_errors);
					end
				end
				check_value("init_done", 32'(init_done), (rise_cnt >= 4) ? 32'd1 : 32'd0,
					delivery_errors);
				if (rise_cnt < n_queued) begin
					exp_cmd = expected[rise_cnt];
					check_value("rs", 32'(cap.rs), 32'(exp_cmd.rs), delivery_errors);
					check_value("rw", 32'(cap.rw), 32'(exp_cmd.rw), delivery_errors);
					check_value("lcd_data", 32'(cap.data), 32'(exp_cmd.data), delivery_errors);
				end else begin
					report_failure("transfer on the panel pins that was never requested",
						delivery_errors);
				end
				rise_cnt = rise_cnt + 1;
				last_rise = cycle;
				last_long = is_long_cmd(cap);
				high_start = cycle;
			end else if (e && e_prev) begin
				check_value("rs", 32'(rs), 32'(cap.rs), shape_errors);  // stable while e high
				check_value("rw", 32'(rw), 32'(cap.rw), shape_errors);
				check_value("lcd_data", 32'(lcd_data), 32'(cap.data), shape_errors);
			end else if (!e && e_prev) begin
				check_value("e_high_cycles", 32'(cycle - high_start), 32'(E_HIGH_CYC),
					shape_errors);
			end
		end
		e_prev = e;
	end

	initial begin
		int          err0;
		int          del0;
		int          gap;
		int          total;
		logic [31:0] r;

		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		rng = 32'd96;
		r = next_rand();
		cfg = lcd_pkg::lcd_cfg_t'(r[6:0]);
		for (int i = 0; i < 4; i++) begin
			expected[i] = setup_cmd_for(i, cfg);
		end
		n_queued = 4;
		$display("cfg 0x%0h", cfg);

		// reset state
		err0 = errors;
		repeat (10) begin
			@(negedge clk);
			check_value("e", 32'(e), 32'd0, errors);
			check_value("credit", 32'(credit), 32'd0, errors);
			check_value("init_done", 32'(init_done), 32'd0, errors);
		end
		rst = 1'b0;
		release_cycle = cycle;
		while (rise_cnt == 0) begin  // quiet until the power-up wait ends
			check_value("credit", 32'(credit), 32'd0, errors);
			check_value("init_done", 32'(init_done), 32'd0, errors);
			@(negedge clk);
		end
		finish_test("reset_state", errors - err0 + early_errors);

		// setup commands from cfg
		err0 = errors;
		while (init_done !== 1'b1) @(negedge clk);
		check_value("setup_transfers", 32'(rise_cnt), 32'd4, errors);
		finish_test("setup_sequence", errors - err0 + delivery_errors);

		// random stream with idle gaps
		err0 = errors;
		del0 = delivery_errors;
		for (int i = 0; i < N_STREAM; i++) begin
			r = next_rand();
			gap = int'(r[3:0]);
			repeat (gap) @(negedge clk);
			send_cmd(random_cmd());
		end
		while (rise_cnt < n_queued) @(negedge clk);
		repeat (LONG_CYC + 10) @(negedge clk);  // let the last slot end and catch extra transfers
		check_value("transfers", 32'(rise_cnt), 32'(4 + N_STREAM), errors);
		finish_test("ordered_delivery", errors - err0 + delivery_errors - del0);

		// burst as fast as credits allow
		err0 = errors;
		del0 = delivery_errors;
		stalled = 1'b0;
		for (int i = 0; i < N_BURST; i++) begin
			send_cmd(random_cmd());
		end
		while (rise_cnt < n_queued) @(negedge clk);
		repeat (LONG_CYC + 10) @(negedge clk);  // let the last slot end and catch extra transfers
		check_value("host_stalled", 32'(stalled), 32'd1, errors);
		check_value("credit_pulses", 32'(credit_pulses), 32'(sent), errors);
		check_value("host_credits", 32'(host_credits()), 32'(DEPTH), errors);
		check_value("transfers", 32'(rise_cnt), 32'(N_EXPECTED), errors);
		finish_test("back_pressure", errors - err0 + delivery_errors - del0 + credit_errors);

		finish_test("pulse_shape", shape_errors);

		total = errors + early_errors + shape_errors + delivery_errors + credit_errors;
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
		if (tests_failed == 0 && total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lcd_subsys.f
common/lcd_pkg.sv
source/lcd_cmd_queue.sv
lcd_ctrl/lcd_init_seq.sv
lcd_ctrl/lcd_bus_cycle.sv
source/lcd_subsys.sv
tests/lcd_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert --timescale 1ns/1ns
TOP        = lcd_tb
FILELIST   = lcd_subsys.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
